// File: compile.f
+incdir+.
la_pkg.sv
la_regs.sv
la_trigger.sv
la_capture_ctrl.sv
la_sampler.sv
la_top.sv
tb_clock.sv
tb_la.sv

// File: la_capture_ctrl.sv
`include "la_cfg.svh"

module la_capture_ctrl
   import la_pkg::*;
(
   input  logic    observer_clk,
   input  logic    reset,
   input  la_cfg_t cfg,
   input  logic    trig_edge,
   input  logic    sample_taken,
   output logic    start,
   output logic    capturing
);

   logic [`LA_CNT_W-1:0] sample_cnt;
   logic [`LA_CNT_W:0]   cnt_next;   // Extra bit, no wrap at full depth

   // Only an armed, idle engine accepts a trigger
   assign start = trig_edge & cfg.arm & ~capturing;

   assign cnt_next = {1'b0, sample_cnt} + 1'b1;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing  <= 1'b0;
         sample_cnt <= '0;
      end else if (start) begin
         capturing  <= 1'b1;
         sample_cnt <= '0;
      end else if (sample_taken) begin
         sample_cnt <= cnt_next[`LA_CNT_W-1:0];
         // Depth 0 ends on the first sample
         if (cnt_next >= {1'b0, cfg.depth})
            capturing <= 1'b0;
      end
   end

endmodule

// File: la_cfg.svh
`ifndef LA_CFG_SVH
`define LA_CFG_SVH

// Datapath sizes
`define LA_NUM_CH                 9
`define LA_WORD_W                 18     // Two samples per channel
`define LA_CNT_W                  16     // Depth and downsample fields

// Register bus
`define LA_ADDR_W                 8
`define LA_DATA_W                 8
`define LA_BYTECNT_W              1      // Byte index within 16-bit fields

// Register map
`define LA_ADDR_CAPTURE_GROUP     8'h00
`define LA_ADDR_TRIGGER_SOURCE    8'h01
`define LA_ADDR_CAPTURE_DEPTH     8'h02
`define LA_ADDR_DOWNSAMPLE        8'h03
`define LA_ADDR_ARM               8'h04
`define LA_ADDR_MANUAL_CAPTURE    8'h05
`define LA_ADDR_STATUS            8'h06

// Reset values
`define LA_GROUP_RESET            3'd0   // IO group
`define LA_TRIG_SRC_RESET         4'd0   // Manual capture only
`define LA_DEPTH_RESET            16'd0
`define LA_DOWNSAMPLE_RESET       16'd0

// Fixed pattern for unused group codes, channel 0 in bit 0
`define LA_ALT_PATTERN            9'h155

`endif

// File: la_pkg.sv
package la_pkg;

   // Probe lines, one 9-bit field per capture group
   typedef struct packed {
      logic [8:0] io;      // io1-4, hs1, hs2, aux_mcx, trig_mcx, adc_sample_clk
      logic [8:0] user;    // userio0-7, userio_clk in bit 8
      logic [8:0] debug;
   } la_probes_t;

   // Capture group select, codes 3-7 give the alternating pattern
   typedef enum logic [2:0] {
      GRP_IO    = 3'd0,
      GRP_USER  = 3'd1,
      GRP_DEBUG = 3'd2
   } la_group_e;

   // Trigger select, 8-15 pick userio0-7
   typedef enum logic [3:0] {
      TRIG_NONE    = 4'd0,
      TRIG_HS1     = 4'd1,
      TRIG_DEBUG0  = 4'd2,
      TRIG_DEBUG1  = 4'd3,
      TRIG_USERIO0 = 4'd8,
      TRIG_USERIO1 = 4'd9,
      TRIG_USERIO2 = 4'd10,
      TRIG_USERIO3 = 4'd11,
      TRIG_USERIO4 = 4'd12,
      TRIG_USERIO5 = 4'd13,
      TRIG_USERIO6 = 4'd14,
      TRIG_USERIO7 = 4'd15
   } la_trig_e;

   // Register contents
   typedef struct packed {
      la_group_e   group;
      la_trig_e    trig_sel;
      logic        trig_inv;     // Only applies to userio sources
      logic [15:0] depth;        // Samples per capture
      logic [15:0] downsample;   // Sample every downsample+1 cycles
      logic        arm;
      logic        manual;
   } la_cfg_t;

   // FIFO word, ch[0] in the low bits, older sample in bit 1 of each field
   typedef struct packed {
      logic [8:0][1:0] ch;
   } la_word_t;

endpackage

// File: la_regs.sv
`include "la_cfg.svh"

module la_regs
   import la_pkg::*;
(
   input  logic                      observer_clk,
   input  logic                      reset,
   input  logic [`LA_ADDR_W-1:0]     reg_addr,
   input  logic [`LA_BYTECNT_W-1:0]  reg_bytecnt,
   input  logic [`LA_DATA_W-1:0]     reg_wdata,
   input  logic                      reg_write,
   input  logic                      reg_read,
   output logic [`LA_DATA_W-1:0]     reg_rdata,
   input  logic                      start,
   input  logic                      capturing,
   output la_cfg_t                   cfg
);

   logic [3:0] byte_base;   // Bit offset of the addressed byte

   assign byte_base = {reg_bytecnt, 3'b000};

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         cfg.group      <= la_group_e'(`LA_GROUP_RESET);
         cfg.trig_sel   <= la_trig_e'(`LA_TRIG_SRC_RESET);
         cfg.trig_inv   <= 1'b0;
         cfg.depth      <= `LA_DEPTH_RESET;
         cfg.downsample <= `LA_DOWNSAMPLE_RESET;
         cfg.manual     <= 1'b0;
         cfg.arm        <= 1'b0;
      end else begin
         if (reg_write) begin
            case (reg_addr)
               `LA_ADDR_CAPTURE_GROUP: cfg.group <= la_group_e'(reg_wdata[2:0]);
               `LA_ADDR_TRIGGER_SOURCE: begin
                  cfg.trig_sel <= la_trig_e'(reg_wdata[3:0]);
                  cfg.trig_inv <= reg_wdata[4];
               end
               `LA_ADDR_CAPTURE_DEPTH:  cfg.depth[byte_base +: 8] <= reg_wdata;
               `LA_ADDR_DOWNSAMPLE:     cfg.downsample[byte_base +: 8] <= reg_wdata;
               `LA_ADDR_MANUAL_CAPTURE: cfg.manual <= reg_wdata[0];
               default: ;
            endcase
         end

         // Bus write wins over the start clear
         if (reg_write && (reg_addr == `LA_ADDR_ARM))
            cfg.arm <= reg_wdata[0];
         else if (start)
            cfg.arm <= 1'b0;   // One capture per arm
      end
   end

   // Read-back
   always_comb begin
      reg_rdata = '0;
      if (reg_read) begin
         case (reg_addr)
            `LA_ADDR_CAPTURE_GROUP:  reg_rdata = {5'b0, cfg.group};
            `LA_ADDR_TRIGGER_SOURCE: reg_rdata = {3'b0, cfg.trig_inv, cfg.trig_sel};
            `LA_ADDR_CAPTURE_DEPTH:  reg_rdata = cfg.depth[byte_base +: 8];
            `LA_ADDR_DOWNSAMPLE:     reg_rdata = cfg.downsample[byte_base +: 8];
            `LA_ADDR_ARM:            reg_rdata = {7'b0, cfg.arm};
            `LA_ADDR_MANUAL_CAPTURE: reg_rdata = {7'b0, cfg.manual};
            `LA_ADDR_STATUS:         reg_rdata = {6'b0, capturing, 1'b0};   // Bit 0 reserved
            default:                 reg_rdata = '0;
         endcase
      end
   end

endmodule

// File: la_sampler.sv
`include "la_cfg.svh"

module la_sampler
   import la_pkg::*;
(
   input  logic       observer_clk,
   input  logic       reset,
   input  la_cfg_t    cfg,
   input  la_probes_t probes,
   input  logic       start,
   input  logic       capturing,
   output logic       sample_taken,
   output logic       fifo_wr,
   output la_word_t   fifo_wr_data
);

   logic [`LA_NUM_CH-1:0] src_q;      // Registered probe group
   logic [`LA_CNT_W-1:0]  ds_ctr;
   logic                  ds_tick;
   logic                  ticktock;   // Set after the first of a sample pair
   logic [`LA_WORD_W-1:0] word_q;     // Two-sample history per channel

   always_ff @(posedge observer_clk) begin
      case (cfg.group)
         GRP_IO:    src_q <= probes.io;
         GRP_USER:  src_q <= probes.user;
         GRP_DEBUG: src_q <= probes.debug;
         default:   src_q <= `LA_ALT_PATTERN;
      endcase
   end

   // Downsample counter, restarted by start
   assign ds_tick      = (ds_ctr == cfg.downsample);
   assign sample_taken = capturing & ds_tick;

   always_ff @(posedge observer_clk) begin
      if (reset)
         ds_ctr <= '0;
      else if (start || ds_tick)
         ds_ctr <= '0;
      else
         ds_ctr <= ds_ctr + 1'b1;
   end

   // Pair tracking and the FIFO strobe
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ticktock <= 1'b0;
         fifo_wr  <= 1'b0;
      end else begin
         fifo_wr <= sample_taken & ticktock;   // Second sample of a pair
         if (start)
            ticktock <= 1'b0;
         else if (sample_taken)
            ticktock <= ~ticktock;
      end
   end

   // Shift in the new sample, older one moves to the high bit
   always_ff @(posedge observer_clk) begin
      if (sample_taken) begin
         for (int i = 0; i < `LA_NUM_CH; i++)
            word_q[2*i +: 2] <= {word_q[2*i], src_q[i]};
      end
   end

   assign fifo_wr_data = la_word_t'(word_q);

endmodule

// File: la_top.sv
module la_top
   import la_pkg::*;
(
   input  logic       observer_clk,
   input  logic       reset,
   input  logic [7:0] reg_addr,
   input  logic       reg_bytecnt,
   input  logic [7:0] reg_wdata,
   input  logic       reg_write,
   input  logic       reg_read,
   output logic [7:0] reg_rdata,
   input  la_probes_t probes,
   output logic       fifo_wr,
   output la_word_t   fifo_wr_data
);

   la_cfg_t cfg;
   logic    trig_edge;
   logic    start;          // Accepted trigger
   logic    capturing;
   logic    sample_taken;

   la_regs u_regs (
      .observer_clk (observer_clk),
      .reset        (reset),
      .reg_addr     (reg_addr),
      .reg_bytecnt  (reg_bytecnt),
      .reg_wdata    (reg_wdata),
      .reg_write    (reg_write),
      .reg_read     (reg_read),
      .reg_rdata    (reg_rdata),
      .start        (start),
      .capturing    (capturing),
      .cfg          (cfg)
   );

   la_trigger u_trigger (
      .observer_clk (observer_clk),
      .reset        (reset),
      .cfg          (cfg),
      .probes       (probes),
      .trig_edge    (trig_edge)
   );

   la_capture_ctrl u_ctrl (
      .observer_clk (observer_clk),
      .reset        (reset),
      .cfg          (cfg),
      .trig_edge    (trig_edge),
      .sample_taken (sample_taken),
      .start        (start),
      .capturing    (capturing)
   );

   la_sampler u_sampler (
      .observer_clk (observer_clk),
      .reset        (reset),
      .cfg          (cfg),
      .probes       (probes),
      .start        (start),
      .capturing    (capturing),
      .sample_taken (sample_taken),
      .fifo_wr      (fifo_wr),
      .fifo_wr_data (fifo_wr_data)
   );

endmodule

// File: la_trace.txt
# name group trig_sel invert depth downsample probes(27-bit hex io:user:debug or rand)
# trigger method (manual, user, noarm, retrig) and expected word count
io_manual     0  0 0   8 0 5a3c1d2 manual 4
user_rise     0 10 0   6 1 rand    user   3
user_fall_inv 0 12 1   6 0 rand    user   3
not_armed     0  9 0   8 0 rand    noarm  0
ds3_even      0  0 0   8 3 rand    manual 4
ds3_odd       0  0 0   7 3 3f0f0f0 manual 3
group_user    1  0 0   6 1 rand    manual 3
group_debug   2  0 0   6 0 rand    manual 3
group_alt     5  0 0   4 2 rand    manual 2
depth_bytes   0  0 0 300 0 rand    manual 150
retrigger     0  0 0  20 1 rand    retrig 10

// File: la_trigger.sv
module la_trigger
   import la_pkg::*;
(
   input  logic       observer_clk,
   input  logic       reset,
   input  la_cfg_t    cfg,
   input  la_probes_t probes,
   output logic       trig_edge
);

   logic       src_sel;    // Selected line, before manual
   logic       trig_src;
   logic [1:0] sync_q;
   logic       hist_q;     // Previous synchronized level

   always_comb begin
      src_sel = 1'b0;
      case (cfg.trig_sel)
         TRIG_NONE:   src_sel = 1'b0;
         TRIG_HS1:    src_sel = probes.io[4];
         TRIG_DEBUG0: src_sel = probes.debug[0];
         TRIG_DEBUG1: src_sel = probes.debug[1];
         default: begin
            // userio0-7, inversion turns it into a falling-edge trigger
            if (cfg.trig_sel[3])
               src_sel = probes.user[cfg.trig_sel[2:0]] ^ cfg.trig_inv;
         end
      endcase
   end

   assign trig_src = src_sel | cfg.manual;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_q    <= 2'b00;
         hist_q    <= 1'b0;
         trig_edge <= 1'b0;
      end else begin
         sync_q    <= {sync_q[0], trig_src};
         hist_q    <= sync_q[1];
         trig_edge <= sync_q[1] & ~hist_q;   // Registered rising edge
      end
   end

endmodule

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_la -f compile.f -o sim_la > build.log 2>&1 \
   && ./obj_dir/sim_la > sim.log 2>&1 \
   || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// File: tb_clock.sv
module tb_clock (
   output logic observer_clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      observer_clk = 1'b0;
      forever #50 observer_clk = ~observer_clk;   // 100 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge observer_clk);
      #10 reset = 1'b0;
   end

endmodule

// File: tb_la.sv
`include "la_cfg.svh"

module tb_la
   import la_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic       observer_clk, reset;
   logic [7:0] reg_addr, reg_wdata, reg_rdata;
   logic       reg_bytecnt, reg_write, reg_read;
   la_probes_t probes;
   logic       fifo_wr;
   la_word_t   fifo_wr_data;

   // One entry per test from the trace
   string      t_name[$], t_probe[$], t_method[$];
   int         t_group[$], t_trig[$], t_inv[$], t_depth[$], t_ds[$], t_count[$];

   logic [31:0] rng = 32'h4f94;
   int          err_cnt = 0;
   int          fail_tests = 0;
   int          wd_limit = 0;
   int          cycle = 0;
   // Monitor state
   logic        mon_on = 1'b0;
   la_word_t    exp_word;
   int          exp_gap, word_cnt, last_wr;

   tb_clock u_clock (.observer_clk(observer_clk), .reset(reset));

   la_top u_la_top (
      .observer_clk (observer_clk),
      .reset        (reset),
      .reg_addr     (reg_addr),
      .reg_bytecnt  (reg_bytecnt),
      .reg_wdata    (reg_wdata),
      .reg_write    (reg_write),
      .reg_read     (reg_read),
      .reg_rdata    (reg_rdata),
      .probes       (probes),
      .fifo_wr      (fifo_wr),
      .fifo_wr_data (fifo_wr_data)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Constant probes give both bits of each field equal to the channel
   function automatic la_word_t double_bits(input logic [8:0] v);
      la_word_t w;
      for (int i = 0; i < 9; i++)
         w.ch[i] = {v[i], v[i]};
      return w;
   endfunction

   function automatic logic [8:0] group_value(input int grp, input logic [26:0] pv);
      case (grp)
         0:       return pv[26:18];   // io
         1:       return pv[17:9];    // user
         2:       return pv[8:0];     // debug
         default: return 9'b101010101;
      endcase
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge observer_clk);
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic bc, input logic [7:0] data);
      @(posedge observer_clk);
      #10;
      reg_addr    = addr;
      reg_bytecnt = bc;
      reg_wdata   = data;
      reg_write   = 1'b1;
      @(posedge observer_clk);
      #10 reg_write = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] addr, input logic bc, output logic [7:0] data);
      @(posedge observer_clk);
      #10;
      reg_addr    = addr;
      reg_bytecnt = bc;
      reg_read    = 1'b1;
      @(negedge observer_clk);
      data = reg_rdata;
      @(posedge observer_clk);
      #10 reg_read = 1'b0;
   endtask

   always @(posedge observer_clk) cycle <= cycle + 1;

   // FIFO word checker samples mid-cycle
   always @(negedge observer_clk) begin
      if (mon_on && fifo_wr) begin
         check("fifo_wr_data", 32'(fifo_wr_data), 32'(exp_word));
         if (word_cnt > 0)
            check("fifo_wr spacing", 32'(cycle - last_wr), 32'(exp_gap));
         last_wr  = cycle;
         word_cnt = word_cnt + 1;
      end
   end

   task automatic reset_test();
      logic [7:0] rd;
      int         e0;
      e0 = err_cnt;
      bus_read(`LA_ADDR_CAPTURE_GROUP, 1'b0, rd);
      check("group after reset", 32'(rd), 32'h0);
      bus_read(`LA_ADDR_TRIGGER_SOURCE, 1'b0, rd);
      check("trigger after reset", 32'(rd), 32'h0);
      for (int b = 0; b < 2; b++) begin
         bus_read(`LA_ADDR_CAPTURE_DEPTH, b[0], rd);
         check("depth after reset", 32'(rd), 32'h0);
         bus_read(`LA_ADDR_DOWNSAMPLE, b[0], rd);
         check("downsample after reset", 32'(rd), 32'h0);
      end
      bus_read(`LA_ADDR_ARM, 1'b0, rd);
      check("arm after reset", 32'(rd), 32'h0);
      bus_read(`LA_ADDR_STATUS, 1'b0, rd);
      check("status after reset", 32'(rd), 32'h0);
      word_cnt = 0;
      mon_on   = 1'b1;
      repeat (40) begin   // Toggle probes with nothing armed
         @(posedge observer_clk);
         rng = xorshift(rng);
         #10 probes = la_probes_t'(rng[26:0]);
      end
      mon_on = 1'b0;
      check("words after reset", 32'(word_cnt), 32'h0);
      if (err_cnt != e0)
         fail_tests++;
      $display("test reset_values: %s", (err_cnt == e0) ? "pass" : "FAIL");
   endtask

   task automatic run_test(input int t);
      logic [26:0] pv;
      logic [7:0]  rd;
      logic        idle;
      int          k, e0, n, budget;
      bit          started;
      e0     = err_cnt;
      k      = t_trig[t] - 8;
      idle   = t_inv[t][0];   // Line idles high when inverted
      budget = t_depth[t] * (t_ds[t] + 1) + 40;
      if (t_probe[t] == "rand") begin
         rng = xorshift(rng);
         pv  = rng[26:0];
      end else begin
         n = $sscanf(t_probe[t], "%h", pv);
         if (n != 1) begin
            $display("test %s: probe value %s in the trace is not hex", t_name[t], t_probe[t]);
            err_cnt++;
         end
      end
      if (t_trig[t] >= 8)
         pv[9 + k] = idle;
      @(posedge observer_clk);
      #10 probes = la_probes_t'(pv);

      bus_write(`LA_ADDR_MANUAL_CAPTURE, 1'b0, 8'h00);
      bus_write(`LA_ADDR_CAPTURE_GROUP, 1'b0, 8'(t_group[t]));
      bus_write(`LA_ADDR_TRIGGER_SOURCE, 1'b0, 8'((t_inv[t] << 4) | t_trig[t]));
      bus_write(`LA_ADDR_CAPTURE_DEPTH, 1'b0, 8'(t_depth[t]));
      bus_write(`LA_ADDR_CAPTURE_DEPTH, 1'b1, 8'(t_depth[t] >> 8));
      bus_write(`LA_ADDR_DOWNSAMPLE, 1'b0, 8'(t_ds[t]));
      bus_write(`LA_ADDR_DOWNSAMPLE, 1'b1, 8'(t_ds[t] >> 8));
      bus_read(`LA_ADDR_CAPTURE_DEPTH, 1'b0, rd);
      check("depth low byte", 32'(rd), 32'(t_depth[t] & 8'hff));
      bus_read(`LA_ADDR_CAPTURE_DEPTH, 1'b1, rd);
      check("depth high byte", 32'(rd), 32'((t_depth[t] >> 8) & 8'hff));
      bus_read(`LA_ADDR_CAPTURE_GROUP, 1'b0, rd);
      check("group", 32'(rd), 32'(t_group[t]));
      wait_cycles(6);   // Let the synchronizer settle

      exp_word = double_bits(group_value(t_group[t], pv));
      exp_gap  = 2 * (t_ds[t] + 1);
      word_cnt = 0;
      mon_on   = 1'b1;
      if (t_method[t] != "noarm")
         bus_write(`LA_ADDR_ARM, 1'b0, 8'h01);
      if (t_trig[t] >= 8) begin
         @(posedge observer_clk);
         #10 probes.user[k] = ~idle;
      end else begin
         bus_write(`LA_ADDR_MANUAL_CAPTURE, 1'b0, 8'h01);
      end

      if (t_count[t] == 0) begin
         wait_cycles(budget);
      end else begin
         started = 1'b0;
         for (int i = 0; i < 20 && !started; i++) begin
            bus_read(`LA_ADDR_STATUS, 1'b0, rd);
            started = rd[1];
         end
         if (!started) begin
            $display("test %s: capture did not start after the trigger", t_name[t]);
            err_cnt++;
         end else begin
            if (t_method[t] == "retrig") begin
               // Re-arm and fire again mid-capture
               bus_write(`LA_ADDR_ARM, 1'b0, 8'h01);
               bus_write(`LA_ADDR_MANUAL_CAPTURE, 1'b0, 8'h00);
               bus_write(`LA_ADDR_MANUAL_CAPTURE, 1'b0, 8'h01);
            end
            for (int i = 0; i < budget && rd[1]; i++)
               bus_read(`LA_ADDR_STATUS, 1'b0, rd);
            if (rd[1]) begin
               $display("test %s: timed out waiting for the capture to end", t_name[t]);
               err_cnt++;
            end
            wait_cycles(4);
         end
      end
      mon_on = 1'b0;

      if (word_cnt < t_count[t]) begin
         $display("test %s: missing words, got %0d of %0d", t_name[t], word_cnt, t_count[t]);
         err_cnt++;
      end else begin
         check("word count", 32'(word_cnt), 32'(t_count[t]));
      end
      if (t_method[t] == "manual" || t_method[t] == "user") begin
         bus_read(`LA_ADDR_ARM, 1'b0, rd);
         check("arm after capture", 32'(rd), 32'h0);
      end
      bus_write(`LA_ADDR_ARM, 1'b0, 8'h00);
      bus_write(`LA_ADDR_MANUAL_CAPTURE, 1'b0, 8'h00);
      if (err_cnt != e0)
         fail_tests++;
      $display("test %s: %s", t_name[t], (err_cnt == e0) ? "pass" : "FAIL");
   endtask

   task automatic read_trace(output bit ok);
      int    fd, n, g, tr, iv, d, ds, c;
      string line, nm, pr, me;
      ok = 1'b0;
      fd = $fopen("la_trace.txt", "r");
      if (fd == 0)
         return;
      while ($fgets(line, fd)) begin
         if (line.len() < 3 || line[0] == "#")
            continue;
         n = $sscanf(line, "%s %d %d %d %d %d %s %s %d", nm, g, tr, iv, d, ds, pr, me, c);
         if (n != 9)
            continue;
         t_name.push_back(nm);
         t_group.push_back(g);
         t_trig.push_back(tr);
         t_inv.push_back(iv);
         t_depth.push_back(d);
         t_ds.push_back(ds);
         t_probe.push_back(pr);
         t_method.push_back(me);
         t_count.push_back(c);
      end
      $fclose(fd);
      ok = (t_name.size() > 0);
   endtask

   // Watchdog limit comes from the capture lengths in the trace
   initial begin
      wait (wd_limit > 0);
      repeat (wd_limit) @(posedge observer_clk);
      $display("Watchdog: run did not finish within %0d cycles", wd_limit);
      $display("Errors found");
      $finish;
   end

   initial begin
      bit ok;
      int total;
      reg_addr    = 8'h00;
      reg_bytecnt = 1'b0;
      reg_wdata   = 8'h00;
      reg_write   = 1'b0;
      reg_read    = 1'b0;
      probes      = '0;
      read_trace(ok);
      if (!ok) begin
         $display("Could not read any test from la_trace.txt");
         $display("Errors found");
         $finish;
      end else begin
         total = 1000 + 300 * t_name.size();
         foreach (t_name[i])
            total += t_depth[i] * (t_ds[i] + 1);
         wd_limit = total;
         wait (!reset);
         reset_test();
         foreach (t_name[i])
            run_test(i);
         $display("Tests run %0d, failed %0d, check errors %0d",
                  t_name.size() + 1, fail_tests, err_cnt);
         if (err_cnt == 0)
            $display("No errors");
         else
            $display("Errors found");
         $finish;
      end
   end

endmodule
